// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    // ------------------------------------------------------------------------
    // widths and base types
    // ------------------------------------------------------------------------
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_alu     = 7'b0110011,
        op_alu_imm = 7'b0010011,
        op_lui     = 7'b0110111,
        op_auipc   = 7'b0010111,
        op_jal     = 7'b1101111,
        op_jalr    = 7'b1100111,
        op_branch  = 7'b1100011,
        op_load    = 7'b0000011,
        op_store   = 7'b0100011,
        op_system  = 7'b1110011
    } op_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        res_alu = 2'd0,
        res_mem = 2'd1,
        res_pc4 = 2'd2,
        res_imm = 2'd3
    } result_src_e;

    // ------------------------------------------------------------------------
    // load/store size codes and byte masks
    // ------------------------------------------------------------------------
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    localparam logic [3:0] mask_byte = 4'b0001;
    localparam logic [3:0] mask_half = 4'b0011;
    localparam logic [3:0] mask_word = 4'b1111;

    localparam word_t pc_step  = 32'd4;
    localparam word_t reset_pc = 32'd0;

endpackage

// ==== verilog/rv_regfile.sv ====
module rv_regfile (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              rf_wen,
    input  rv_pkg::reg_addr_t rf_waddr,
    input  rv_pkg::word_t     rf_wdata
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    // same-cycle write is bypassed to the reader
    function automatic rv_pkg::word_t read_port(rv_pkg::reg_addr_t addr);
        rv_pkg::word_t value;
        if (addr == '0)
            value = '0;
        else if (rf_wen && rf_waddr == addr)
            value = rf_wdata;
        else
            value = regs[addr];
        return value;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (rf_wen) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

endmodule

// ==== verilog/rv_decode.sv ====
module rv_decode (
    input  logic                clk,
    input  logic                rst,
    output rv_pkg::word_t       instr_addr,
    input  rv_pkg::word_t       instr_data,
    input  logic                redirect,
    input  rv_pkg::word_t       redirect_pc,
    output rv_pkg::reg_addr_t   rs1_addr,
    output rv_pkg::reg_addr_t   rs2_addr,
    input  rv_pkg::word_t       rs1_data,
    input  rv_pkg::word_t       rs2_data,
    output logic                d_valid,
    output rv_pkg::word_t       d_pc,
    output rv_pkg::op_e         d_op,
    output rv_pkg::alu_op_e     d_alu_op,
    output logic [2:0]          d_funct3,
    output logic                d_imm_src,
    output rv_pkg::result_src_e d_result_src,
    output rv_pkg::reg_addr_t   d_rd,
    output rv_pkg::reg_addr_t   d_rs1,
    output rv_pkg::reg_addr_t   d_rs2,
    output rv_pkg::word_t       d_imm,
    output rv_pkg::word_t       d_rs1_data,
    output rv_pkg::word_t       d_rs2_data
);

    rv_pkg::word_t pc;
    logic          fd_valid;
    rv_pkg::word_t fd_pc;
    rv_pkg::word_t fd_instr;
    logic          stopped;
    logic          ebreak_now;
    logic          stop;
    rv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    // funct3/funct7 to ALU operation; sub only exists in register form
    function automatic rv_pkg::alu_op_e alu_sel(logic [2:0] f3, logic alt, logic reg_form);
        rv_pkg::alu_op_e sel;
        case (f3)
            3'b000:  sel = (alt && reg_form) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  sel = rv_pkg::alu_sll;
            3'b010:  sel = rv_pkg::alu_slt;
            3'b011:  sel = rv_pkg::alu_sltu;
            3'b100:  sel = rv_pkg::alu_xor;
            3'b101:  sel = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  sel = rv_pkg::alu_or;
            default: sel = rv_pkg::alu_and;
        endcase
        return sel;
    endfunction

    // ------------------------------------------------------------------------
    // fetch: PC and fetch/decode register
    // ------------------------------------------------------------------------
    // a squashed ebreak must not stop fetch
    assign ebreak_now = fd_valid && d_op == rv_pkg::op_system && !redirect;
    assign stop       = stopped || ebreak_now;
    assign instr_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= rv_pkg::reset_pc;
            fd_valid <= 1'b0;
            stopped  <= 1'b0;
        end else begin
            if (redirect)
                pc <= redirect_pc;
            else if (!stop)
                pc <= pc + rv_pkg::pc_step;
            fd_valid <= !redirect && !stop;
            if (ebreak_now)
                stopped <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        fd_pc    <= pc;
        fd_instr <= instr_data;
    end

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------
    assign imm_i = {{20{fd_instr[31]}}, fd_instr[31:20]};
    assign imm_s = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
    assign imm_b = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7], fd_instr[30:25],
                    fd_instr[11:8], 1'b0};
    assign imm_u = {fd_instr[31:12], 12'b0};
    assign imm_j = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12], fd_instr[20],
                    fd_instr[30:21], 1'b0};

    assign d_op     = rv_pkg::op_e'(fd_instr[6:0]);
    assign d_funct3 = fd_instr[14:12];
    assign rs1_addr = fd_instr[19:15];
    assign rs2_addr = fd_instr[24:20];

    always_comb begin
        d_alu_op     = rv_pkg::alu_add;
        d_imm_src    = 1'b1;
        d_result_src = rv_pkg::res_alu;
        d_rd         = fd_instr[11:7];
        d_imm        = imm_i;
        case (d_op)
            rv_pkg::op_alu: begin
                d_imm_src = 1'b0;
                d_alu_op  = alu_sel(d_funct3, fd_instr[30], 1'b1);
            end
            rv_pkg::op_alu_imm: d_alu_op = alu_sel(d_funct3, fd_instr[30], 1'b0);
            rv_pkg::op_lui: begin
                d_result_src = rv_pkg::res_imm;
                d_imm        = imm_u;
            end
            rv_pkg::op_auipc: d_imm = imm_u;
            rv_pkg::op_jal: begin
                d_result_src = rv_pkg::res_pc4;
                d_imm        = imm_j;
            end
            rv_pkg::op_jalr: d_result_src = rv_pkg::res_pc4;
            rv_pkg::op_branch: begin
                d_imm_src = 1'b0;
                d_imm     = imm_b;
                d_rd      = '0;
            end
            rv_pkg::op_load: d_result_src = rv_pkg::res_mem;
            rv_pkg::op_store: begin
                d_imm = imm_s;
                d_rd  = '0;
            end
            // system and unknown opcodes write nothing
            default: d_rd = '0;
        endcase
    end

    assign d_valid    = fd_valid;
    assign d_pc       = fd_pc;
    assign d_rs1      = rs1_addr;
    assign d_rs2      = rs2_addr;
    assign d_rs1_data = rs1_data;
    assign d_rs2_data = rs2_data;

endmodule

// ==== verilog/rv_execute.sv ====
module rv_execute (
    input  logic                clk,
    input  logic                rst,
    input  logic                d_valid,
    input  rv_pkg::word_t       d_pc,
    input  rv_pkg::op_e         d_op,
    input  rv_pkg::alu_op_e     d_alu_op,
    input  logic [2:0]          d_funct3,
    input  logic                d_imm_src,
    input  rv_pkg::result_src_e d_result_src,
    input  rv_pkg::reg_addr_t   d_rd,
    input  rv_pkg::reg_addr_t   d_rs1,
    input  rv_pkg::reg_addr_t   d_rs2,
    input  rv_pkg::word_t       d_imm,
    input  rv_pkg::word_t       d_rs1_data,
    input  rv_pkg::word_t       d_rs2_data,
    input  logic                rf_wen,
    input  rv_pkg::reg_addr_t   rf_waddr,
    input  rv_pkg::word_t       rf_wdata,
    output logic                redirect,
    output rv_pkg::word_t       redirect_pc,
    output logic                e_valid,
    output rv_pkg::word_t       e_pc,
    output rv_pkg::op_e         e_op,
    output rv_pkg::result_src_e e_result_src,
    output logic [2:0]          e_funct3,
    output rv_pkg::reg_addr_t   e_rd,
    output rv_pkg::word_t       e_result,
    output rv_pkg::word_t       e_store_data
);

    logic                ex_valid;
    rv_pkg::word_t       ex_pc;
    rv_pkg::op_e         ex_op;
    rv_pkg::alu_op_e     ex_alu_op;
    logic [2:0]          ex_funct3;
    logic                ex_imm_src;
    rv_pkg::result_src_e ex_result_src;
    rv_pkg::reg_addr_t   ex_rd, ex_rs1, ex_rs2;
    rv_pkg::word_t       ex_imm, ex_rs1_data, ex_rs2_data;

    rv_pkg::word_t rs1_val, rs2_val;
    rv_pkg::word_t op_a, op_b;
    rv_pkg::word_t alu_res;
    logic          cmp;
    logic          taken;

    // ------------------------------------------------------------------------
    // decode/execute register
    // ------------------------------------------------------------------------
    // the instruction behind a taken branch becomes a bubble
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ex_valid <= 1'b0;
        else
            ex_valid <= d_valid && !redirect;
    end

    always_ff @(posedge clk) begin
        ex_pc         <= d_pc;
        ex_op         <= d_op;
        ex_alu_op     <= d_alu_op;
        ex_funct3     <= d_funct3;
        ex_imm_src    <= d_imm_src;
        ex_result_src <= d_result_src;
        ex_rd         <= d_rd;
        ex_rs1        <= d_rs1;
        ex_rs2        <= d_rs2;
        ex_imm        <= d_imm;
        ex_rs1_data   <= d_rs1_data;
        ex_rs2_data   <= d_rs2_data;
    end

    // forward from result; the register file covers anything older
    assign rs1_val = (rf_wen && rf_waddr == ex_rs1) ? rf_wdata : ex_rs1_data;
    assign rs2_val = (rf_wen && rf_waddr == ex_rs2) ? rf_wdata : ex_rs2_data;

    assign op_a = (ex_op == rv_pkg::op_auipc) ? ex_pc : rs1_val;
    assign op_b = ex_imm_src ? ex_imm : rs2_val;

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (ex_alu_op)
            rv_pkg::alu_sub:  alu_res = op_a - op_b;
            rv_pkg::alu_and:  alu_res = op_a & op_b;
            rv_pkg::alu_or:   alu_res = op_a | op_b;
            rv_pkg::alu_xor:  alu_res = op_a ^ op_b;
            rv_pkg::alu_slt:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu: alu_res = {31'b0, op_a < op_b};
            rv_pkg::alu_sll:  alu_res = op_a << op_b[4:0];
            rv_pkg::alu_srl:  alu_res = op_a >> op_b[4:0];
            rv_pkg::alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
            default:          alu_res = op_a + op_b;
        endcase
    end

    // funct3[2:1] picks the compare, funct3[0] inverts it
    always_comb begin
        case (ex_funct3[2:1])
            2'b00:   cmp = rs1_val == rs2_val;
            2'b10:   cmp = $signed(rs1_val) < $signed(rs2_val);
            2'b11:   cmp = rs1_val < rs2_val;
            default: cmp = 1'b0;
        endcase
    end

    assign taken = ex_op == rv_pkg::op_branch && ex_funct3[2:1] != 2'b01
                   && (cmp ^ ex_funct3[0]);

    assign redirect = ex_valid && (taken || ex_op == rv_pkg::op_jal
                                   || ex_op == rv_pkg::op_jalr);
    assign redirect_pc = (ex_op == rv_pkg::op_jalr) ? {alu_res[31:1], 1'b0}
                                                    : ex_pc + ex_imm;

    always_comb begin
        case (ex_result_src)
            rv_pkg::res_pc4: e_result = ex_pc + rv_pkg::pc_step;
            rv_pkg::res_imm: e_result = ex_imm;
            // load/store address comes out of the ALU too
            default:         e_result = alu_res;
        endcase
    end

    assign e_valid      = ex_valid;
    assign e_pc         = ex_pc;
    assign e_op         = ex_op;
    assign e_result_src = ex_result_src;
    assign e_funct3     = ex_funct3;
    assign e_rd         = ex_rd;
    assign e_store_data = rs2_val;

endmodule

// ==== verilog/rv_result.sv ====
module rv_result (
    input  logic                clk,
    input  logic                rst,
    input  logic                e_valid,
    input  rv_pkg::word_t       e_pc,
    input  rv_pkg::op_e         e_op,
    input  rv_pkg::result_src_e e_result_src,
    input  logic [2:0]          e_funct3,
    input  rv_pkg::reg_addr_t   e_rd,
    input  rv_pkg::word_t       e_result,
    input  rv_pkg::word_t       e_store_data,
    output rv_pkg::word_t       mem_addr,
    output rv_pkg::word_t       mem_wdata,
    output logic [3:0]          mem_wmask,
    output logic                mem_wen,
    output logic                mem_ren,
    input  rv_pkg::word_t       mem_rdata,
    output logic                rf_wen,
    output rv_pkg::reg_addr_t   rf_waddr,
    output rv_pkg::word_t       rf_wdata,
    output logic                retire_valid,
    output rv_pkg::word_t       retire_pc,
    output logic                halt
);

    logic                r_valid;
    rv_pkg::word_t       r_pc;
    rv_pkg::op_e         r_op;
    rv_pkg::result_src_e r_result_src;
    logic [2:0]          r_funct3;
    rv_pkg::reg_addr_t   r_rd;
    rv_pkg::word_t       r_result;
    rv_pkg::word_t       r_store_data;
    rv_pkg::word_t       load_data;

    // retire_pc keeps the last retired PC while bubbles pass through
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r_valid <= 1'b0;
            r_pc    <= rv_pkg::reset_pc;
            halt    <= 1'b0;
        end else begin
            r_valid <= e_valid;
            if (e_valid)
                r_pc <= e_pc;
            if (r_valid && r_op == rv_pkg::op_system)
                halt <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (e_valid) begin
            r_op         <= e_op;
            r_result_src <= e_result_src;
            r_funct3     <= e_funct3;
            r_rd         <= e_rd;
            r_result     <= e_result;
            r_store_data <= e_store_data;
        end
    end

    // ------------------------------------------------------------------------
    // data memory port
    // ------------------------------------------------------------------------
    assign mem_addr  = r_result;
    assign mem_wdata = r_store_data;
    assign mem_wen   = r_valid && r_op == rv_pkg::op_store;
    assign mem_ren   = r_valid && r_op == rv_pkg::op_load;

    always_comb begin
        case (r_funct3)
            rv_pkg::f3_byte: mem_wmask = rv_pkg::mask_byte;
            rv_pkg::f3_half: mem_wmask = rv_pkg::mask_half;
            default:         mem_wmask = rv_pkg::mask_word;
        endcase
    end

    always_comb begin
        case (r_funct3)
            rv_pkg::f3_byte:   load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
            rv_pkg::f3_half:   load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
            rv_pkg::f3_byte_u: load_data = {24'b0, mem_rdata[7:0]};
            rv_pkg::f3_half_u: load_data = {16'b0, mem_rdata[15:0]};
            default:           load_data = mem_rdata;
        endcase
    end

    // decode zeroes rd for anything that writes no register
    assign rf_wen   = r_valid && r_rd != '0;
    assign rf_waddr = r_rd;
    assign rf_wdata = (r_result_src == rv_pkg::res_mem) ? load_data : r_result;

    assign retire_valid = r_valid;
    assign retire_pc    = r_pc;

endmodule

// ==== verilog/rv_core.sv ====
module rv_core (
    input  logic          clk,
    input  logic          rst,
    output rv_pkg::word_t instr_addr,
    input  rv_pkg::word_t instr_data,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    output logic [3:0]    mem_wmask,
    output logic          mem_wen,
    output logic          mem_ren,
    input  rv_pkg::word_t mem_rdata,
    output logic          retire_valid,
    output rv_pkg::word_t retire_pc,
    output logic          halt
);

    rv_pkg::reg_addr_t   rs1_addr, rs2_addr;
    rv_pkg::word_t       rs1_data, rs2_data;
    logic                redirect;
    rv_pkg::word_t       redirect_pc;

    // decode to execute
    logic                d_valid;
    rv_pkg::word_t       d_pc;
    rv_pkg::op_e         d_op;
    rv_pkg::alu_op_e     d_alu_op;
    logic [2:0]          d_funct3;
    logic                d_imm_src;
    rv_pkg::result_src_e d_result_src;
    rv_pkg::reg_addr_t   d_rd, d_rs1, d_rs2;
    rv_pkg::word_t       d_imm, d_rs1_data, d_rs2_data;

    // execute to result
    logic                e_valid;
    rv_pkg::word_t       e_pc;
    rv_pkg::op_e         e_op;
    rv_pkg::result_src_e e_result_src;
    logic [2:0]          e_funct3;
    rv_pkg::reg_addr_t   e_rd;
    rv_pkg::word_t       e_result, e_store_data;

    // write-back, also the forwarding source
    logic                rf_wen;
    rv_pkg::reg_addr_t   rf_waddr;
    rv_pkg::word_t       rf_wdata;

    rv_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .d_valid      (d_valid),
        .d_pc         (d_pc),
        .d_op         (d_op),
        .d_alu_op     (d_alu_op),
        .d_funct3     (d_funct3),
        .d_imm_src    (d_imm_src),
        .d_result_src (d_result_src),
        .d_rd         (d_rd),
        .d_rs1        (d_rs1),
        .d_rs2        (d_rs2),
        .d_imm        (d_imm),
        .d_rs1_data   (d_rs1_data),
        .d_rs2_data   (d_rs2_data)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rf_wen   (rf_wen),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

    rv_execute u_execute (
        .clk          (clk),
        .rst          (rst),
        .d_valid      (d_valid),
        .d_pc         (d_pc),
        .d_op         (d_op),
        .d_alu_op     (d_alu_op),
        .d_funct3     (d_funct3),
        .d_imm_src    (d_imm_src),
        .d_result_src (d_result_src),
        .d_rd         (d_rd),
        .d_rs1        (d_rs1),
        .d_rs2        (d_rs2),
        .d_imm        (d_imm),
        .d_rs1_data   (d_rs1_data),
        .d_rs2_data   (d_rs2_data),
        .rf_wen       (rf_wen),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .e_valid      (e_valid),
        .e_pc         (e_pc),
        .e_op         (e_op),
        .e_result_src (e_result_src),
        .e_funct3     (e_funct3),
        .e_rd         (e_rd),
        .e_result     (e_result),
        .e_store_data (e_store_data)
    );

    rv_result u_result (
        .clk          (clk),
        .rst          (rst),
        .e_valid      (e_valid),
        .e_pc         (e_pc),
        .e_op         (e_op),
        .e_result_src (e_result_src),
        .e_funct3     (e_funct3),
        .e_rd         (e_rd),
        .e_result     (e_result),
        .e_store_data (e_store_data),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_wmask    (mem_wmask),
        .mem_wen      (mem_wen),
        .mem_ren      (mem_ren),
        .mem_rdata    (mem_rdata),
        .rf_wen       (rf_wen),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .halt         (halt)
    );

endmodule

// ==== testbench/rv_core_chk.sv ====
module rv_core_chk (
    input logic          clk,
    input logic          rst,
    input logic          mem_wen,
    input logic          mem_ren,
    input logic [3:0]    mem_wmask,
    input logic          retire_valid,
    input rv_pkg::word_t retire_pc,
    input logic          halt
);

    a_mem_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_wen && mem_ren))
        else $error("load and store on the data port in the same cycle");

    a_wmask: assert property (@(posedge clk) disable iff (rst)
        mem_wen |-> (mem_wmask == rv_pkg::mask_byte || mem_wmask == rv_pkg::mask_half
                     || mem_wmask == rv_pkg::mask_word))
        else $error("store with an illegal byte mask");

    a_retire_align: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_pc[1:0] == 2'b00)
        else $error("retire_pc not word aligned");

    // nothing retires after ebreak
    a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
        halt |-> !retire_valid)
        else $error("instruction retired after halt");

endmodule

bind rv_core rv_core_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .mem_wen      (mem_wen),
    .mem_ren      (mem_ren),
    .mem_wmask    (mem_wmask),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .halt         (halt)
);

// ==== testbench/rv_core_tb.sv ====
module rv_core_tb;

    localparam logic [31:0] nop_word = 32'h0000_0013;

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    rv_pkg::word_t instr_addr;
    rv_pkg::word_t instr_data;
    rv_pkg::word_t mem_addr;
    rv_pkg::word_t mem_wdata;
    logic [3:0]    mem_wmask;
    logic          mem_wen;
    logic          mem_ren;
    rv_pkg::word_t mem_rdata;
    logic          retire_valid;
    rv_pkg::word_t retire_pc;
    logic          halt;

    // program image and expected stores
    logic [31:0] imem [0:255];
    int          n_words;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_mask [$];
    logic [31:0] halt_pc;

    logic [7:0]  dmem [0:1023];

    int          cycle;
    int          limit;
    int          store_idx;
    bit          have_prev;
    logic [31:0] prev_pc;

    always #20 clk = ~clk;

    rv_core uut (
        .clk          (clk),
        .rst          (rst),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_wmask    (mem_wmask),
        .mem_wen      (mem_wen),
        .mem_ren      (mem_ren),
        .mem_rdata    (mem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .halt         (halt)
    );

    // ------------------------------------------------------------------------
    // memory models
    // ------------------------------------------------------------------------
    // fetches past the program return nop
    assign instr_data = (int'(instr_addr[31:2]) < n_words) ? imem[instr_addr[9:2]] : nop_word;

    assign mem_rdata = {dmem[mem_addr[9:0] + 10'd3], dmem[mem_addr[9:0] + 10'd2],
                        dmem[mem_addr[9:0] + 10'd1], dmem[mem_addr[9:0]]};

    always @(posedge clk) begin
        if (mem_wen) begin
            for (int k = 0; k < 4; k++) begin
                if (mem_wmask[k])
                    dmem[mem_addr[9:0] + 10'(k)] <= mem_wdata[8*k +: 8];
            end
        end
    end

    // ------------------------------------------------------------------------
    // reporting and checks
    // ------------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
    endtask

    function automatic logic [31:0] lane_bits(logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // next PC is either sequential or the target the ISA allows
    function automatic bit legal_successor(logic [31:0] prev, logic [31:0] pc);
        logic [31:0] instr;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        bit          ok;
        instr = imem[prev[9:2]];
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        ok    = (pc == prev + 32'd4);
        case (instr[6:0])
            7'b1100011: ok = ok || (pc == prev + imm_b);
            7'b1101111: ok = ok || (pc == prev + imm_j);
            // a jalr target comes from a register and may be any program word
            7'b1100111: ok = ok || (pc[1:0] == 2'b00 && int'(pc[31:2]) < n_words);
            default:    ok = ok;
        endcase
        return ok;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("testbench/rv_core_vectors.txt", "r");
        if (fd == 0)
            abort_run("cannot open testbench/rv_core_vectors.txt");
        n_words = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#")
                continue;
            if (line[0] == "P") begin
                code = $sscanf(line, "P %h", a);
                imem[n_words[7:0]] = a;
                n_words++;
            end else if (line[0] == "S") begin
                code = $sscanf(line, "S %h %h %h", a, b, c);
                exp_addr.push_back(a);
                exp_data.push_back(b);
                exp_mask.push_back(c[3:0]);
            end else if (line[0] == "H") begin
                code = $sscanf(line, "H %h", a);
                halt_pc = a;
            end else begin
                abort_run($sformatf("bad line in vector file: %s", line));
            end
        end
        $fclose(fd);
    endtask

    task automatic check_cycle();
        logic [31:0] retired_word;
        retired_word = imem[retire_pc[9:2]];
        // first instruction retires three cycles after its fetch
        if (cycle < 3)
            check_value("retire_valid", 32'(retire_valid), 32'd0);
        if (cycle == 3) begin
            check_value("retire_valid", 32'(retire_valid), 32'd1);
            check_value("retire_pc", retire_pc, 32'd0);
        end
        if (retire_valid) begin
            if (have_prev && !legal_successor(prev_pc, retire_pc))
                abort_run($sformatf("illegal control flow: pc %h retired after pc %h",
                                    retire_pc, prev_pc));
            prev_pc   = retire_pc;
            have_prev = 1'b1;
        end
        // only a retiring load reads data memory
        check_value("mem_ren", 32'(mem_ren),
                    32'(retire_valid && retired_word[6:0] == 7'b0000011));
        if (mem_wen) begin
            if (store_idx >= exp_addr.size())
                abort_run($sformatf("unexpected extra store to address %h", mem_addr));
            check_value("mem_addr", mem_addr, exp_addr[store_idx]);
            check_value("mem_wmask", 32'(mem_wmask), 32'(exp_mask[store_idx]));
            check_value("mem_wdata", mem_wdata & lane_bits(mem_wmask), exp_data[store_idx]);
            store_idx++;
        end
        if (cycle >= limit)
            abort_run($sformatf("timeout: halt was not raised within %0d cycles", limit));
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        for (int i = 0; i < 1024; i++)
            dmem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        load_vectors();
        limit     = 8 * n_words + 100;
        cycle     = 0;
        store_idx = 0;
        have_prev = 1'b0;
        prev_pc   = '0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // outputs are sampled half a cycle after the edge
        forever begin
            @(negedge clk);
            check_cycle();
            if (halt)
                break;
            cycle++;
        end

        check_value("retire_pc", retire_pc, halt_pc);
        check_value("store_count", 32'(store_idx), 32'(exp_addr.size()));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== testbench/rv_core_vectors.txt ====
# P word : program word in hex, in address order from 0
# S addr data mask : expected store in order, data masked to its lanes; H pc : halt pc
# ---- ALU chain, base x10 = 0x200
P 20000513
P FF900093
P 00C08113
P 002081B3
P 00352023
P 40110233
P 00452223
P 0020C2B3
P 00226333
P 0062F3B3
P 00552423
P 00752623
# ---- shifts
P 00409413
P 40245493
P 0024D5B3
P 00952823
P 00B52A23
# ---- compares, stored as bytes and a half
P 0020A633
P 0020B6B3
P FFF13713
P 00C50C23
P 00D50CA3
P 00E51D23
# ---- lui, auipc
P 123457B7
P 00001817
P 00F52E23
P 03052023
# ---- loads and their stores
P 01852883
P 00050903
P 00054983
P 01051A03
P 01455A83
P 03152223
P 03252423
P 03352623
P 03452823
P 03552A23
# ---- branches, not taken then taken, two poison words after each
P 08208463
P 00210663
P 00002023
P 00002023
P 06211C63
P 00209663
P 00002023
P 00002023
P 06114463
P 0020C663
P 00002023
P 00002023
P 0420DC63
P 00115663
P 00002023
P 00002023
P 0420E463
P 00116663
P 00002023
P 00002023
P 02117C63
P 0020F663
P 00002023
P 00002023
# ---- jal, auipc + jalr with odd offset
P 00C00BEF
P 00002023
P 00002023
P 00000C97
P 011C8C67
P 00002023
P 00002023
P 03752C23
P 03852E23
# ebreak, then the poison word that wrong branches land on
P 00100073
P 00002023
S 200 FFFFFFFE F
S 204 0000000C F
S 208 FFFFFFFC F
S 20C 0000000C F
S 210 FFFFFFE4 F
S 214 07FFFFFF F
S 218 00000001 1
S 219 00000000 1
S 21A 00000001 3
S 21C 12345000 F
S 220 00001060 F
S 224 00010001 F
S 228 FFFFFFFE F
S 22C 000000FE F
S 230 FFFFFFE4 F
S 234 0000FFFF F
S 238 000000F8 F
S 23C 00000108 F
H 118

// ==== compile.f ====
verilog/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
testbench/rv_core_chk.sv
testbench/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --assert --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
